// ==== cache.f ====
cache_geom_pkg.sv
cache_ctrl_pkg.sv
cache_line_ram.sv
cache_data_array.sv
cache_tag_store.sv
cache_byte_align.sv
cache_ctrl_fsm.sv
cache_top.sv
cache_tb.sv

// ==== cache_byte_align.sv ====
`timescale 1ns/100ps

module cache_byte_align (
   input  cache_geom_pkg::cpu_req_t   req,
   input  cache_geom_pkg::line_t      rline,
   output cache_geom_pkg::line_t      wline,
   output cache_geom_pkg::byte_mask_t wmask,
   output cache_geom_pkg::line_t      rdata
);

   cache_geom_pkg::offset_t offset;
   logic [cache_geom_pkg::offset_w+2:0] bit_shift;
   cache_geom_pkg::byte_mask_t size_mask;

   assign offset = req.addr[cache_geom_pkg::offset_w-1:0];

   // byte offset as a bit count
   assign bit_shift = {offset, 3'b000};

   // write data moves up to its byte offset, zero fill below
   assign wline = req.wdata << bit_shift;

   // read line moves down to bit 0, zero fill above the line end
   assign rdata = rline >> bit_shift;

   // n ones for size code n, whole line for code 0
   always_comb
   begin
      if (req.size == '0)
      begin
         size_mask = '1;
      end
      else
      begin
         size_mask = (cache_geom_pkg::byte_mask_t'(1) << req.size)
                   - cache_geom_pkg::byte_mask_t'(1);
      end
   end

   // bytes past the line end fall off the top
   assign wmask = size_mask << offset;

endmodule

// ==== cache_ctrl_fsm.sv ====
`timescale 1ns/100ps

module cache_ctrl_fsm (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  enable,
   input  logic                  rw,
   input  logic                  hit,
   input  logic                  evict,
   input  logic                  bus_ready,
   output cache_ctrl_pkg::ctrl_t ctrl
);

   cache_ctrl_pkg::state_t state_q;
   cache_ctrl_pkg::state_t state_d;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state_q <= cache_ctrl_pkg::idle;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   // next state
   always_comb
   begin
      state_d = state_q;
      unique case (state_q)
         cache_ctrl_pkg::idle:
         begin
            if (enable)
            begin
               state_d = rw ? cache_ctrl_pkg::wr : cache_ctrl_pkg::rd;
            end
         end
         cache_ctrl_pkg::rd:
         begin
            if (hit)
               state_d = cache_ctrl_pkg::rd_hit;
            else if (evict)
               state_d = cache_ctrl_pkg::rd_evict;
            else
               state_d = cache_ctrl_pkg::rd_miss;
         end
         cache_ctrl_pkg::wr:
         begin
            if (hit)
               state_d = cache_ctrl_pkg::wr_hit;
            else if (evict)
               state_d = cache_ctrl_pkg::wr_evict;
            else
               state_d = cache_ctrl_pkg::wr_miss;
         end
         // write-back done, go fetch the line
         cache_ctrl_pkg::rd_evict:
         begin
            if (bus_ready)
               state_d = cache_ctrl_pkg::rd_miss;
         end
         cache_ctrl_pkg::wr_evict:
         begin
            if (bus_ready)
               state_d = cache_ctrl_pkg::wr_miss;
         end
         // fill done, finish as a hit
         cache_ctrl_pkg::rd_miss:
         begin
            if (bus_ready)
               state_d = cache_ctrl_pkg::rd_hit;
         end
         cache_ctrl_pkg::wr_miss:
         begin
            if (bus_ready)
               state_d = cache_ctrl_pkg::wr_hit;
         end
         cache_ctrl_pkg::rd_hit,
         cache_ctrl_pkg::wr_hit:
         begin
            state_d = cache_ctrl_pkg::idle;
         end
         default:
         begin
            state_d = cache_ctrl_pkg::idle;
         end
      endcase
   end

   // strobes straight from the state
   always_comb
   begin
      ctrl = '0;
      unique case (state_q)
         cache_ctrl_pkg::rd_miss,
         cache_ctrl_pkg::wr_miss:
         begin
            ctrl.data_wr = 1'b1;
            ctrl.fill_sel = 1'b1;
            ctrl.bus_en = 1'b1;
         end
         cache_ctrl_pkg::rd_evict,
         cache_ctrl_pkg::wr_evict:
         begin
            ctrl.bus_en = 1'b1;
            ctrl.bus_wr = 1'b1;
         end
         cache_ctrl_pkg::rd_hit:
         begin
            ctrl.tag_wr = 1'b1;
            ctrl.ready = 1'b1;
         end
         cache_ctrl_pkg::wr_hit:
         begin
            ctrl.data_wr = 1'b1;
            ctrl.tag_wr = 1'b1;
            ctrl.ready = 1'b1;
         end
         default:
         begin
            ctrl = '0;
         end
      endcase
   end

   a_bus_wr_en: assert property (
      @(posedge clk) disable iff (!arst_n) ctrl.bus_wr |-> ctrl.bus_en
   );

   a_ready_pulse: assert property (
      @(posedge clk) disable iff (!arst_n) ctrl.ready |=> !ctrl.ready
   );

endmodule

// ==== cache_ctrl_pkg.sv ====
package cache_ctrl_pkg;

   // one-hot controller states
   typedef enum logic [8:0] {
      idle     = 9'b0_0000_0001,
      rd       = 9'b0_0000_0010,
      rd_hit   = 9'b0_0000_0100,
      rd_miss  = 9'b0_0000_1000,
      rd_evict = 9'b0_0001_0000,
      wr       = 9'b0_0010_0000,
      wr_hit   = 9'b0_0100_0000,
      wr_miss  = 9'b0_1000_0000,
      wr_evict = 9'b1_0000_0000
   } state_t;

   // control strobes decoded from the state
   typedef struct packed {
      // write the data array
      logic data_wr;
      // line comes from the bus, all bytes written
      logic fill_sel;
      // write tag entry and set valid
      logic tag_wr;
      logic bus_en;
      logic bus_wr;
      logic ready;
   } ctrl_t;

endpackage

// ==== cache_data_array.sv ====
`timescale 1ns/100ps

module cache_data_array (
   input  logic                       clk,
   input  cache_geom_pkg::index_t     index,
   input  cache_geom_pkg::line_t      wline,
   input  cache_geom_pkg::byte_mask_t wmask,
   output cache_geom_pkg::line_t      rline
);

   // one byte-wide RAM per lane, all lanes share the index
   for (genvar lane = 0; lane < cache_geom_pkg::line_bytes; lane++)
   begin : g_lane
      cache_line_ram #(
         .payload_t (cache_geom_pkg::byte_t)
      ) lane_ram_i (
         .clk   (clk),
         .index (index),
         .we    (wmask[lane]),
         .wdata (wline[8*lane +: 8]),
         .rdata (rline[8*lane +: 8])
      );
   end

endmodule

// ==== cache_geom_pkg.sv ====
package cache_geom_pkg;

   // byte address split as tag | index | offset
   localparam int addr_w = 16;
   localparam int tag_w = 7;
   localparam int index_w = 5;
   localparam int offset_w = 4;

   // 32 lines of 16 bytes
   localparam int num_lines = 32;
   localparam int line_bytes = 16;

   typedef logic [addr_w-1:0] addr_t;
   typedef logic [tag_w-1:0] tag_t;
   typedef logic [index_w-1:0] index_t;
   typedef logic [offset_w-1:0] offset_t;

   typedef logic [7:0] byte_t;
   typedef logic [line_bytes*8-1:0] line_t;

   // one write enable per byte lane, active high
   typedef logic [line_bytes-1:0] byte_mask_t;

   // 1, 2, 4 or 8 bytes, 0 selects the whole line
   typedef logic [3:0] size_t;

   // one word of the tag RAM
   typedef struct packed {
      logic dirty;
      tag_t tag;
   } tag_entry_t;

   // processor request, held until ready
   typedef struct packed {
      logic  rw;
      addr_t addr;
      size_t size;
      line_t wdata;
   } cpu_req_t;

   // bus request, en and wr held until bus_ready
   typedef struct packed {
      logic  en;
      logic  wr;
      addr_t addr;
      line_t wdata;
   } bus_req_t;

endpackage

// ==== cache_line_ram.sv ====
`timescale 1ns/100ps

module cache_line_ram #(
   parameter type payload_t = logic
) (
   input  logic                   clk,
   input  cache_geom_pkg::index_t index,
   input  logic                   we,
   input  payload_t               wdata,
   output payload_t               rdata
);

   // one entry per cache line
   payload_t mem [cache_geom_pkg::num_lines];

   // write at the clock edge
   always_ff @(posedge clk)
   begin
      if (we)
      begin
         mem[index] <= wdata;
      end
   end

   // asynchronous read port
   assign rdata = mem[index];

endmodule

// ==== cache_tag_store.sv ====
`timescale 1ns/100ps

module cache_tag_store (
   input  logic                  clk,
   input  logic                  arst_n,
   input  cache_geom_pkg::addr_t addr,
   input  logic                  dirty_in,
   input  logic                  tag_wr,
   output logic                  hit,
   output logic                  evict,
   output cache_geom_pkg::tag_t  victim_tag
);

   cache_geom_pkg::index_t index;
   cache_geom_pkg::tag_t tag;
   cache_geom_pkg::tag_entry_t rentry;
   cache_geom_pkg::tag_entry_t wentry;
   logic [cache_geom_pkg::num_lines-1:0] valid_q;

   assign index = addr[cache_geom_pkg::offset_w +: cache_geom_pkg::index_w];
   assign tag = addr[cache_geom_pkg::addr_w-1 -: cache_geom_pkg::tag_w];

   // a read hit keeps a line dirty, a fill starts from rw
   assign wentry.tag = tag;
   assign wentry.dirty = dirty_in | (hit & rentry.dirty);

   cache_line_ram #(
      .payload_t (cache_geom_pkg::tag_entry_t)
   ) tag_ram_i (
      .clk   (clk),
      .index (index),
      .we    (tag_wr),
      .wdata (wentry),
      .rdata (rentry)
   );

   // valid bits, set on the first tag write of a line
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         valid_q <= '0;
      end
      else if (tag_wr)
      begin
         valid_q[index] <= 1'b1;
      end
   end

   assign hit = valid_q[index] && (rentry.tag == tag);

   // only a dirty victim needs a write-back
   assign evict = valid_q[index] && rentry.dirty && (rentry.tag != tag);
   assign victim_tag = rentry.tag;

   a_hit_evict_excl: assert property (
      @(posedge clk) disable iff (!arst_n) !(hit && evict)
   );

endmodule

// ==== cache_tb.sv ====
`timescale 1ns/100ps

module cache_tb;

   localparam int clk_period = 20;
   localparam int num_rows = 17;
   localparam logic [15:0] lfsr_seed = 16'd21195;

   logic clk;
   logic arst_n;
   logic enable;
   cache_geom_pkg::cpu_req_t req;
   cache_geom_pkg::line_t rdata;
   logic ready;
   cache_geom_pkg::bus_req_t bus;
   logic bus_ready;
   cache_geom_pkg::line_t bus_rdata;

   cache_geom_pkg::cpu_req_t stim [num_rows];
   cache_geom_pkg::byte_t bus_mem [65536];
   cache_geom_pkg::byte_t ref_mem [65536];
   // shadow of what the cache should hold
   logic sh_valid [cache_geom_pkg::num_lines];
   logic sh_dirty [cache_geom_pkg::num_lines];
   cache_geom_pkg::tag_t sh_tag [cache_geom_pkg::num_lines];
   cache_geom_pkg::line_t sh_line [cache_geom_pkg::num_lines];
   logic [15:0] lfsr_q;
   int n_checks;
   int n_errors;
   int wb_count;
   int fill_count;
   cache_geom_pkg::addr_t wb_addr;
   cache_geom_pkg::addr_t fill_addr;
   cache_geom_pkg::line_t wb_data;

   cache_top dut_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .enable    (enable),
      .req       (req),
      .rdata     (rdata),
      .ready     (ready),
      .bus       (bus),
      .bus_ready (bus_ready),
      .bus_rdata (bus_rdata)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #(clk_period / 2);
         clk = ~clk;
      end
   end

   function automatic logic [15:0] galois_step(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
   endfunction

   // one lfsr step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_q = galois_step(lfsr_q);
         v = {v[30:0], lfsr_q[0]};
      end
      return v;
   endfunction

   function automatic cache_geom_pkg::cpu_req_t make_req(
      input logic                  rw,
      input cache_geom_pkg::addr_t addr,
      input cache_geom_pkg::size_t size,
      input cache_geom_pkg::line_t wdata
   );
      cache_geom_pkg::cpu_req_t r;
      r.rw = rw;
      r.addr = addr;
      r.size = size;
      r.wdata = wdata;
      return r;
   endfunction

   task automatic check_line(
      input string                 name,
      input cache_geom_pkg::line_t got,
      input cache_geom_pkg::line_t exp
   );
      n_checks++;
      if (got !== exp)
      begin
         n_errors++;
         $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_addr(
      input string                 name,
      input cache_geom_pkg::addr_t got,
      input cache_geom_pkg::addr_t exp
   );
      n_checks++;
      if (got !== exp)
      begin
         n_errors++;
         $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      n_checks++;
      if (got !== exp)
      begin
         n_errors++;
         $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      end
   endtask

   // expected outcome of one access, shadow state moves on as the cache should
   task automatic predict(
      input  cache_geom_pkg::cpu_req_t r,
      output logic                     hit,
      output logic                     wb,
      output cache_geom_pkg::addr_t    wb_a,
      output cache_geom_pkg::line_t    wb_line,
      output cache_geom_pkg::line_t    rd
   );
      cache_geom_pkg::index_t ix;
      cache_geom_pkg::tag_t tg;
      int off;
      int nbytes;
      ix = r.addr[cache_geom_pkg::offset_w +: cache_geom_pkg::index_w];
      tg = r.addr[cache_geom_pkg::addr_w-1 -: cache_geom_pkg::tag_w];
      off = int'(r.addr[cache_geom_pkg::offset_w-1:0]);
      nbytes = (r.size == '0) ? cache_geom_pkg::line_bytes : int'(r.size);
      hit = sh_valid[ix] && (sh_tag[ix] == tg);
      wb = !hit && sh_valid[ix] && sh_dirty[ix];
      wb_a = {sh_tag[ix], ix, 4'h0};
      wb_line = sh_line[ix];
      rd = '0;
      if (wb)
      begin
         for (int b = 0; b < 16; b++)
            ref_mem[int'(wb_a) + b] = wb_line[8*b +: 8];
      end
      if (!hit)
      begin
         for (int b = 0; b < 16; b++)
            sh_line[ix][8*b +: 8] = ref_mem[int'(r.addr & 16'hfff0) + b];
         sh_valid[ix] = 1'b1;
         sh_tag[ix] = tg;
         sh_dirty[ix] = 1'b0;
      end
      if (r.rw)
      begin
         // bytes past the line end are dropped
         for (int b = 0; b < 16; b++)
            if (b >= off && b - off < nbytes)
               sh_line[ix][8*b +: 8] = r.wdata[8*(b-off) +: 8];
         sh_dirty[ix] = 1'b1;
      end
      else
      begin
         for (int i = 0; i < 16; i++)
            if (i + off < 16)
               rd[8*i +: 8] = sh_line[ix][8*(i+off) +: 8];
      end
   endtask

   task automatic run_row(input int row);
      cache_geom_pkg::cpu_req_t r;
      cache_geom_pkg::line_t exp_rd;
      cache_geom_pkg::line_t exp_wb_line;
      cache_geom_pkg::addr_t exp_wb_addr;
      logic exp_hit;
      logic exp_wb;
      int wb_before;
      int fill_before;
      int cycles;
      r = stim[row];
      predict(r, exp_hit, exp_wb, exp_wb_addr, exp_wb_line, exp_rd);
      wb_before = wb_count;
      fill_before = fill_count;
      @(posedge clk);
      enable <= 1'b1;
      req <= r;
      cycles = 0;
      do
      begin
         @(negedge clk);
         cycles++;
         // hit answers two cycles after the enable cycle
         if (exp_hit && cycles <= 3)
            check_bit("ready", ready, cycles == 3);
      end
      while (!ready);
      if (!r.rw)
         check_line("rdata", rdata, exp_rd);
      @(posedge clk);
      enable <= 1'b0;
      check_bit("bus write-back seen", wb_count != wb_before, exp_wb);
      check_bit("bus fill seen", fill_count != fill_before, !exp_hit);
      if (exp_wb)
      begin
         check_addr("bus.addr write-back", wb_addr, exp_wb_addr);
         check_line("bus.wdata", wb_data, exp_wb_line);
      end
      if (!exp_hit)
         check_addr("bus.addr fill", fill_addr, r.addr & 16'hfff0);
   endtask

   // memory side, answers each request after 1 to 4 cycles
   initial
   begin : bus_model
      int delay;
      int base;
      logic is_wr;
      cache_geom_pkg::line_t fill_line;
      @(posedge arst_n);
      forever
      begin
         @(negedge clk);
         if (bus.en)
         begin
            base = int'(bus.addr);
            is_wr = bus.wr;
            if (is_wr)
            begin
               wb_count++;
               wb_addr = bus.addr;
               wb_data = bus.wdata;
               for (int b = 0; b < 16; b++)
                  bus_mem[base + b] = bus.wdata[8*b +: 8];
            end
            else
            begin
               fill_count++;
               fill_addr = bus.addr;
               for (int b = 0; b < 16; b++)
                  fill_line[8*b +: 8] = bus_mem[base + b];
            end
            delay = 1 + int'(take_bits(2));
            repeat (delay) @(posedge clk);
            bus_ready <= 1'b1;
            if (!is_wr)
               bus_rdata <= fill_line;
            @(posedge clk);
            bus_ready <= 1'b0;
         end
      end
   end

   initial
   begin
      #((40 * num_rows + 100) * clk_period);
      $display("watchdog: run did not finish within %0d cycles", 40 * num_rows + 100);
      $display("sim failed");
      $finish;
   end

   initial
   begin
      arst_n = 1'b0;
      enable = 1'b0;
      req = '0;
      bus_ready = 1'b0;
      bus_rdata = '0;
      n_checks = 0;
      n_errors = 0;
      wb_count = 0;
      fill_count = 0;
      lfsr_q = lfsr_seed;
      for (int a = 0; a < 65536; a++)
      begin
         bus_mem[a] = cache_geom_pkg::byte_t'(take_bits(8));
         ref_mem[a] = bus_mem[a];
      end
      for (int i = 0; i < cache_geom_pkg::num_lines; i++)
      begin
         sh_valid[i] = 1'b0;
         sh_dirty[i] = 1'b0;
         sh_tag[i] = '0;
         sh_line[i] = '0;
      end
      // miss on an empty line, then byte writes of every size on it
      stim[0] = make_req(1'b0, 16'h1235, 4'd8, '0);
      stim[1] = make_req(1'b0, 16'h123c, 4'd8, '0);
      stim[2] = make_req(1'b1, 16'h1231, 4'd1, {{15{8'hee}}, 8'ha5});
      stim[3] = make_req(1'b1, 16'h1236, 4'd2, {{14{8'hee}}, 16'hb2b1});
      stim[4] = make_req(1'b1, 16'h123a, 4'd4, {{12{8'hee}}, 32'hc4c3c2c1});
      stim[5] = make_req(1'b1, 16'h123c, 4'd8, {{8{8'hee}}, 64'hd8d7d6d5d4d3d2d1});
      stim[6] = make_req(1'b0, 16'h1230, 4'd0, '0);
      stim[7] = make_req(1'b1, 16'h1230, 4'd0, 128'h00112233_44556677_8899aabb_ccddeeff);
      stim[8] = make_req(1'b0, 16'h1230, 4'd0, '0);
      // same index, other tags: dirty and clean victims
      stim[9] = make_req(1'b0, 16'h1434, 4'd4, '0);
      stim[10] = make_req(1'b1, 16'h1632, 4'd2, {{14{8'hee}}, 16'h5a5b});
      stim[11] = make_req(1'b0, 16'h1230, 4'd0, '0);
      // write miss, read hit keeps the line dirty
      stim[12] = make_req(1'b1, 16'h2007, 4'd4, {{12{8'hee}}, 32'h0badf00d});
      stim[13] = make_req(1'b0, 16'h2003, 4'd1, '0);
      stim[14] = make_req(1'b0, 16'h2200, 4'd0, '0);
      stim[15] = make_req(1'b1, 16'h3fff, 4'd8, {{8{8'hee}}, 64'h01234567_89abcdef});
      stim[16] = make_req(1'b0, 16'h3ff0, 4'd0, '0);
      repeat (3) @(posedge clk);
      arst_n <= 1'b1;
      @(negedge clk);
      check_bit("ready", ready, 1'b0);
      check_bit("bus.en", bus.en, 1'b0);
      check_bit("bus.wr", bus.wr, 1'b0);
      for (int row = 0; row < num_rows; row++)
         run_row(row);
      repeat (2) @(posedge clk);
      $display("checks %0d, errors %0d", n_checks, n_errors);
      if (n_errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

// ==== cache_top.sv ====
`timescale 1ns/100ps

module cache_top (
   input  logic                     clk,
   input  logic                     arst_n,
   input  logic                     enable,
   input  cache_geom_pkg::cpu_req_t req,
   output cache_geom_pkg::line_t    rdata,
   output logic                     ready,
   output cache_geom_pkg::bus_req_t bus,
   input  logic                     bus_ready,
   input  cache_geom_pkg::line_t    bus_rdata
);

   cache_ctrl_pkg::ctrl_t ctrl;
   logic hit;
   logic evict;
   cache_geom_pkg::tag_t victim_tag;
   cache_geom_pkg::tag_t req_tag;
   cache_geom_pkg::index_t index;
   cache_geom_pkg::line_t rline;
   cache_geom_pkg::line_t cpu_wline;
   cache_geom_pkg::line_t wline;
   cache_geom_pkg::byte_mask_t byte_mask;
   cache_geom_pkg::byte_mask_t wmask;

   assign index = req.addr[cache_geom_pkg::offset_w +: cache_geom_pkg::index_w];
   assign req_tag = req.addr[cache_geom_pkg::addr_w-1 -: cache_geom_pkg::tag_w];

   cache_ctrl_fsm fsm_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .enable    (enable),
      .rw        (req.rw),
      .hit       (hit),
      .evict     (evict),
      .bus_ready (bus_ready),
      .ctrl      (ctrl)
   );

   cache_tag_store tag_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .addr       (req.addr),
      .dirty_in   (req.rw),
      .tag_wr     (ctrl.tag_wr),
      .hit        (hit),
      .evict      (evict),
      .victim_tag (victim_tag)
   );

   cache_byte_align align_i (
      .req   (req),
      .rline (rline),
      .wline (cpu_wline),
      .wmask (byte_mask),
      .rdata (rdata)
   );

   cache_data_array data_i (
      .clk   (clk),
      .index (index),
      .wline (wline),
      .wmask (wmask),
      .rline (rline)
   );

   // fills take the bus line whole and processor writes only their bytes
   assign wline = ctrl.fill_sel ? bus_rdata : cpu_wline;
   assign wmask = ctrl.fill_sel ? '1 : (ctrl.data_wr ? byte_mask : '0);

   assign ready = ctrl.ready;

   // write-back goes to the victim's address and fill to the request's
   always_comb
   begin
      bus.en = ctrl.bus_en;
      bus.wr = ctrl.bus_wr;
      bus.addr = ctrl.bus_wr ? {victim_tag, index, cache_geom_pkg::offset_t'(0)}
                             : {req_tag, index, cache_geom_pkg::offset_t'(0)};
      bus.wdata = rline;
   end

   // size code 0 or a single byte count
   a_size_legal: assert property (
      @(posedge clk) disable iff (!arst_n)
      enable |-> (req.size == '0) || $onehot(req.size)
   );

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the cache testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
   --top-module cache_tb -f cache.f -o cache_sim

./obj_dir/cache_sim | tee sim.log

if grep -q "sim failed" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
